//--- dv/layer_patterns.txt
// First word: layer count. Per layer: wei addr, wei nburst, wei last bytes, ftm addr,
// ftm nburst, ftm last bytes, sufficient mode, request count; then per request:
// stream (0 weights, 1 feature maps), addr, nburst.
4
// Layer 0: sufficient never, all weights first.
00001000 6 40 00008000 3 80 0 3
0 00001000 4
0 00001200 2
1 00008000 3
// Layer 1: sufficient after the first weight chunk.
00020000 9 08 00030000 5 18 1 5
0 00020000 4
1 00030000 4
1 00030200 1
0 00020200 4
0 00020400 1
// Layer 2: single weight burst, then feature maps.
00004000 1 80 00005000 8 80 1 3
0 00004000 1
1 00005000 4
1 00005200 4
// Layer 3: one chunk per stream.
00006000 4 10 00007000 2 08 0 2
0 00006000 4
1 00007000 2

//--- dv/tb_layer_loader.sv
`timescale 1ns/1ps

module tb_layer_loader
	import load_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int MAX_LAYERS = 8;
	localparam int MAX_REQS   = 64;
	localparam int PAT_WORDS  = 256;

	logic        aclk = 1'b0;
	logic        aresetn;
	logic        desc_we;
	layer_desc_t desc;
	logic        desc_ready;
	logic        wb_full = 1'b0;
	logic        fb_full = 1'b0;
	logic        wb_sufficient;
	logic        rd_start;
	rd_req_t     rd_req;
	logic        rd_beat = 1'b0;
	beat_t       rd_data = '0;
	cu_mask_t    wb_we;
	cu_mask_t    fb_we;
	beat_t       buf_data;
	logic        layer_done;

	// Pattern contents.
	logic [31:0] pat [0:PAT_WORDS-1];
	layer_desc_t layer_desc [MAX_LAYERS];
	logic        suff_mode [MAX_LAYERS];
	int          req_end [MAX_LAYERS];
	logic        exp_ftm [MAX_REQS];
	rd_req_t     exp_req [MAX_REQS];
	int          n_layers;
	int          n_reqs;
	int          wd_cycles;
	logic        patterns_loaded = 1'b0;

	// Monitor state.
	int          req_idx = 0;
	int          cur_layer = 0;
	int          done_cnt = 0;
	int          wei_reqs = 0;
	int          chunk_id = 0;
	int          chunk_beats = 0;
	int          recv_beats = 0;
	logic        chunk_ftm = 1'b0;
	addr_t       chunk_addr = '0;
	nburst_t     rem [2];
	last_bytes_t lbytes [2];
	int          stream_beats [2];
	logic        post_reset = 1'b1;
	logic        ready_check = 1'b0;
	int          value_errs = 0;
	int          proto_errs = 0;

	// Memory model state.
	logic [31:0] rng = 32'h08f076eb;
	int          drv_id = 0;
	int          sent = 0;

	layer_loader u_dut (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.desc_we_i       (desc_we),
		.desc_i          (desc),
		.desc_ready_o    (desc_ready),
		.wb_full_i       (wb_full),
		.fb_full_i       (fb_full),
		.wb_sufficient_i (wb_sufficient),
		.rd_start_o      (rd_start),
		.rd_req_o        (rd_req),
		.rd_beat_i       (rd_beat),
		.rd_data_i       (rd_data),
		.wb_we_o         (wb_we),
		.fb_we_o         (fb_we),
		.buf_data_o      (buf_data),
		.layer_done_o    (layer_done)
	);

	always #(CLK_PERIOD / 2) aclk = ~aclk;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Beats of the next chunk of at most UNIT_BURSTS bursts.
	function automatic int chunk_beat_count(input nburst_t rem_bursts, input last_bytes_t lb);
		int bytes;
		if (rem_bursts <= nburst_t'(UNIT_BURSTS)) begin
			// Final burst carries only lb bytes.
			bytes = (int'(rem_bursts) - 1) * int'(BURST_BYTES) + int'(lb);
		end else begin
			bytes = int'(UNIT_BURSTS) * int'(BURST_BYTES);
		end
		return bytes / int'(BEAT_BYTES);
	endfunction

	function automatic int stream_beat_total(input stream_desc_t s);
		return ((int'(s.nburst) - 1) * int'(BURST_BYTES) + int'(s.last_bytes))
			/ int'(BEAT_BYTES);
	endfunction

	task automatic check_req(input string name, input rd_req_t got, input rd_req_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(input string name, input cu_mask_t got, input cu_mask_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_beat(input string name, input beat_t got, input beat_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		proto_errs++;
		$display("Failure at %0d ns: %s", $time, what);
	endtask

	task automatic load_patterns();
		int p;
		int l;
		int r;
		int cnt;
		$readmemh("dv/layer_patterns.txt", pat);
		n_layers  = int'(pat[0]);
		n_reqs    = 0;
		wd_cycles = 0;
		p         = 1;
		for (l = 0; l < n_layers; l++) begin
			layer_desc[l].wei.addr       = pat[p];
			layer_desc[l].wei.nburst     = nburst_t'(pat[p + 1]);
			layer_desc[l].wei.last_bytes = last_bytes_t'(pat[p + 2]);
			layer_desc[l].ftm.addr       = pat[p + 3];
			layer_desc[l].ftm.nburst     = nburst_t'(pat[p + 4]);
			layer_desc[l].ftm.last_bytes = last_bytes_t'(pat[p + 5]);
			suff_mode[l] = pat[p + 6][0];
			cnt = int'(pat[p + 7]);
			p = p + 8;
			for (r = 0; r < cnt; r++) begin
				exp_ftm[n_reqs]        = pat[p][0];
				exp_req[n_reqs].addr   = pat[p + 1];
				exp_req[n_reqs].nburst = nburst_t'(pat[p + 2]);
				n_reqs++;
				p = p + 3;
			end
			req_end[l] = n_reqs;
			wd_cycles = wd_cycles + 200 + 4 * (stream_beat_total(layer_desc[l].wei)
				+ stream_beat_total(layer_desc[l].ftm));
		end
	endtask

	// Memory model and random back-pressure.
	always @(negedge aclk) begin
		rng = next_random(rng);
		wb_full = (rng[31:30] == 2'b11);
		rng = next_random(rng);
		fb_full = (rng[31:30] == 2'b11);
		rng = next_random(rng);
		if (drv_id != chunk_id) begin
			drv_id = chunk_id;
			sent   = 0;
		end
		if (aresetn && sent < chunk_beats && rng[31:29] != 3'b000) begin
			rd_beat = 1'b1;
			rd_data = beat_t'(chunk_addr) + beat_t'(sent * int'(BEAT_BYTES));
			sent++;
		end else begin
			rd_beat = 1'b0;
			rd_data = '0;
		end
	end

	always @(posedge aclk) begin
		int       s;
		int       n;
		cu_mask_t exp_wb;
		cu_mask_t exp_fb;
		if (aresetn) begin
			exp_wb = '0;
			exp_fb = '0;
			if (post_reset) begin
				if (!desc_ready || rd_start || layer_done) begin
					report_failure("outputs were not idle after reset");
				end
				post_reset = 1'b0;
			end
			if (ready_check) begin
				if (!desc_ready) begin
					report_failure("desc_ready_o stayed low after layer_done_o");
				end
				ready_check = 1'b0;
			end
			if (desc_we && desc_ready) begin
				rem[0]          = desc.wei.nburst;
				lbytes[0]       = desc.wei.last_bytes;
				rem[1]          = desc.ftm.nburst;
				lbytes[1]       = desc.ftm.last_bytes;
				stream_beats[0] = 0;
				stream_beats[1] = 0;
				wei_reqs        = 0;
			end
			if (rd_start) begin
				if (desc_ready) begin
					report_failure("read request issued while idle");
				end else if (req_idx >= req_end[cur_layer]) begin
					report_failure("read request beyond the expected list");
				end else begin
					check_req("rd_req_o", rd_req, exp_req[req_idx]);
					if (exp_ftm[req_idx] ? fb_full : wb_full) begin
						report_failure("read request issued while the buffer was full");
					end
					if (recv_beats != chunk_beats) begin
						report_failure("read request issued before the previous chunk ended");
					end
					s = exp_ftm[req_idx] ? 1 : 0;
					n = (rem[s] <= nburst_t'(UNIT_BURSTS)) ? int'(rem[s]) : int'(UNIT_BURSTS);
					chunk_beats = chunk_beat_count(rem[s], lbytes[s]);
					rem[s]      = rem[s] - nburst_t'(n);
					chunk_ftm   = exp_ftm[req_idx];
					chunk_addr  = exp_req[req_idx].addr;
					recv_beats  = 0;
					chunk_id++;
					req_idx++;
					if (s == 0) begin
						wei_reqs++;
					end
				end
			end
			if (rd_beat) begin
				s = chunk_ftm ? 1 : 0;
				// One unit per beat in turn from layer start.
				if (chunk_ftm) begin
					exp_fb = cu_mask_t'(1) << (stream_beats[1] % int'(N_CONV_UNIT));
				end else begin
					exp_wb = cu_mask_t'(1) << (stream_beats[0] % int'(N_CONV_UNIT));
				end
				check_beat("buf_data_o", buf_data,
					beat_t'(chunk_addr) + beat_t'(recv_beats * int'(BEAT_BYTES)));
				recv_beats++;
				stream_beats[s]++;
			end
			check_mask("wb_we_o", wb_we, exp_wb);
			check_mask("fb_we_o", fb_we, exp_fb);
			if (layer_done) begin
				if (req_idx != req_end[cur_layer] || recv_beats != chunk_beats) begin
					report_failure("layer_done_o pulsed before the final beat of the layer");
				end
				done_cnt++;
				cur_layer++;
				ready_check = 1'b1;
			end
		end
	end

	initial begin
		wait (patterns_loaded);
		#(wd_cycles * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the layer loads did not finish", wd_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int l;
		aresetn       = 1'b0;
		desc_we       = 1'b0;
		desc          = '0;
		wb_sufficient = 1'b0;
		load_patterns();
		patterns_loaded = 1'b1;
		repeat (16) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
		repeat (2) @(negedge aclk);
		for (l = 0; l < n_layers; l++) begin
			desc    = layer_desc[l];
			desc_we = 1'b1;
			@(negedge aclk);
			desc_we = 1'b0;
			// Weight buffers report sufficient once the first weight read is out.
			if (suff_mode[l]) begin
				wait (wei_reqs > 0);
				@(negedge aclk);
				wb_sufficient = 1'b1;
			end
			wait (done_cnt == l + 1);
			@(negedge aclk);
			wb_sufficient = 1'b0;
		end
		repeat (8) @(negedge aclk);
		$display("Run complete: %0d value errors, %0d protocol errors", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- hdl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter
	import load_pkg::*;
(
	input  logic      aclk,
	input  logic      aresetn,
	input  logic      init_i,
	input  logic      beat_i,
	input  byte_cnt_t expect_i,
	output logic      pending_o,
	output cu_sel_t   cu_sel_o
);

	// Bytes received since layer start.
	byte_cnt_t count_r;
	cu_sel_t   sel_r;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			count_r <= '0;
			sel_r   <= '0;
		end else if (init_i) begin
			count_r <= '0;
			sel_r   <= '0;
		end else if (beat_i) begin
			count_r <= count_r + byte_cnt_t'(BEAT_BYTES);
			// Next unit, wrapping after the last one.
			if (sel_r == cu_sel_t'(N_CONV_UNIT - 1)) begin
				sel_r <= '0;
			end else begin
				sel_r <= sel_r + cu_sel_t'(1);
			end
		end
	end

	// Chunk still open while the totals differ.
	assign pending_o = (count_r != expect_i);
	assign cu_sel_o  = sel_r;

endmodule

//--- hdl/layer_loader.sv
`timescale 1ns/1ps

module layer_loader
	import load_pkg::*;
(
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        desc_we_i,
	input  layer_desc_t desc_i,
	output logic        desc_ready_o,
	input  logic        wb_full_i,
	input  logic        fb_full_i,
	input  logic        wb_sufficient_i,
	output logic        rd_start_o,
	output rd_req_t     rd_req_o,
	input  logic        rd_beat_i,
	input  beat_t       rd_data_i,
	output cu_mask_t    wb_we_o,
	output cu_mask_t    fb_we_o,
	output beat_t       buf_data_o,
	output logic        layer_done_o
);

	// Weight stream.
	rd_req_t   wei_chunk;
	logic      wei_last;
	logic      wei_exhausted;
	byte_cnt_t wei_expect;
	logic      wei_pending;
	cu_sel_t   wei_cu_sel;
	logic      wei_init;
	logic      wei_advance;
	logic      wei_beat;

	// Feature-map stream.
	rd_req_t   ftm_chunk;
	logic      ftm_last;
	logic      ftm_exhausted;
	byte_cnt_t ftm_expect;
	logic      ftm_pending;
	cu_sel_t   ftm_cu_sel;
	logic      ftm_init;
	logic      ftm_advance;
	logic      ftm_beat;

	stream_chunker u_wei_chunker (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.init_i      (wei_init),
		.advance_i   (wei_advance),
		.desc_i      (desc_i.wei),
		.chunk_o     (wei_chunk),
		.last_o      (wei_last),
		.exhausted_o (wei_exhausted),
		.expect_o    (wei_expect)
	);

	stream_chunker u_ftm_chunker (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.init_i      (ftm_init),
		.advance_i   (ftm_advance),
		.desc_i      (desc_i.ftm),
		.chunk_o     (ftm_chunk),
		.last_o      (ftm_last),
		.exhausted_o (ftm_exhausted),
		.expect_o    (ftm_expect)
	);

	beat_counter u_wei_beats (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.init_i    (wei_init),
		.beat_i    (wei_beat),
		.expect_i  (wei_expect),
		.pending_o (wei_pending),
		.cu_sel_o  (wei_cu_sel)
	);

	beat_counter u_ftm_beats (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.init_i    (ftm_init),
		.beat_i    (ftm_beat),
		.expect_i  (ftm_expect),
		.pending_o (ftm_pending),
		.cu_sel_o  (ftm_cu_sel)
	);

	load_scheduler u_sched (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.desc_we_i       (desc_we_i),
		.desc_ready_o    (desc_ready_o),
		.wb_full_i       (wb_full_i),
		.fb_full_i       (fb_full_i),
		.wb_sufficient_i (wb_sufficient_i),
		.rd_beat_i       (rd_beat_i),
		.rd_data_i       (rd_data_i),
		.rd_start_o      (rd_start_o),
		.rd_req_o        (rd_req_o),
		.wei_chunk_i     (wei_chunk),
		.wei_last_i      (wei_last),
		.wei_exhausted_i (wei_exhausted),
		.wei_pending_i   (wei_pending),
		.wei_cu_sel_i    (wei_cu_sel),
		.ftm_chunk_i     (ftm_chunk),
		.ftm_last_i      (ftm_last),
		.ftm_exhausted_i (ftm_exhausted),
		.ftm_pending_i   (ftm_pending),
		.ftm_cu_sel_i    (ftm_cu_sel),
		.wei_init_o      (wei_init),
		.wei_advance_o   (wei_advance),
		.wei_beat_o      (wei_beat),
		.ftm_init_o      (ftm_init),
		.ftm_advance_o   (ftm_advance),
		.ftm_beat_o      (ftm_beat),
		.wb_we_o         (wb_we_o),
		.fb_we_o         (fb_we_o),
		.buf_data_o      (buf_data_o),
		.layer_done_o    (layer_done_o)
	);

endmodule

//--- hdl/load_pkg.sv
package load_pkg;

	// Data path geometry.
	localparam int unsigned BEAT_BYTES  = 8;
	localparam int unsigned BURST_BEATS = 16;
	localparam int unsigned BURST_BYTES = BEAT_BYTES * BURST_BEATS;

	// Largest read chunk in bursts, kept a power of two.
	localparam int unsigned UNIT_BURSTS = 4;

	// Convolution units fed round-robin.
	localparam int unsigned N_CONV_UNIT = 8;

	typedef logic [31:0]                      addr_t;
	typedef logic [24:0]                      nburst_t;
	// Valid bytes of the final burst, 8 to 128.
	typedef logic [7:0]                       last_bytes_t;
	typedef logic [31:0]                      byte_cnt_t;
	typedef logic [BEAT_BYTES*8-1:0]          beat_t;
	typedef logic [$clog2(N_CONV_UNIT)-1:0]   cu_sel_t;
	typedef logic [N_CONV_UNIT-1:0]           cu_mask_t;

	// One stream of a layer.
	typedef struct packed {
		addr_t       addr;
		nburst_t     nburst;
		last_bytes_t last_bytes;
	} stream_desc_t;

	typedef struct packed {
		stream_desc_t wei;
		stream_desc_t ftm;
	} layer_desc_t;

	// Read request for one chunk.
	typedef struct packed {
		addr_t   addr;
		nburst_t nburst;
	} rd_req_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WEI_HOLD,
		ST_WEI_WAIT,
		ST_FTM_HOLD,
		ST_FTM_WAIT
	} load_state_t;

endpackage

//--- hdl/load_scheduler.sv
`timescale 1ns/1ps

module load_scheduler
	import load_pkg::*;
(
	input  logic     aclk,
	input  logic     aresetn,
	input  logic     desc_we_i,
	output logic     desc_ready_o,
	input  logic     wb_full_i,
	input  logic     fb_full_i,
	input  logic     wb_sufficient_i,
	input  logic     rd_beat_i,
	input  beat_t    rd_data_i,
	output logic     rd_start_o,
	output rd_req_t  rd_req_o,
	input  rd_req_t  wei_chunk_i,
	input  logic     wei_last_i,
	input  logic     wei_exhausted_i,
	input  logic     wei_pending_i,
	input  cu_sel_t  wei_cu_sel_i,
	input  rd_req_t  ftm_chunk_i,
	input  logic     ftm_last_i,
	input  logic     ftm_exhausted_i,
	input  logic     ftm_pending_i,
	input  cu_sel_t  ftm_cu_sel_i,
	output logic     wei_init_o,
	output logic     wei_advance_o,
	output logic     wei_beat_o,
	output logic     ftm_init_o,
	output logic     ftm_advance_o,
	output logic     ftm_beat_o,
	output cu_mask_t wb_we_o,
	output cu_mask_t fb_we_o,
	output beat_t    buf_data_o,
	output logic     layer_done_o
);

	load_state_t state_r;
	load_state_t state_nxt;
	logic        accept;
	logic        ftm_active;

	assign desc_ready_o = (state_r == ST_IDLE);
	assign accept       = desc_we_i && desc_ready_o;

	// Weights until sufficient, then feature maps, then the rest of the weights.
	always_comb begin
		state_nxt    = state_r;
		layer_done_o = 1'b0;
		case (state_r)
			ST_IDLE: begin
				if (accept) begin
					state_nxt = ST_WEI_HOLD;
				end
			end
			ST_WEI_HOLD: begin
				if (!wb_full_i) begin
					state_nxt = ST_WEI_WAIT;
				end
			end
			ST_WEI_WAIT: begin
				if (!wei_pending_i) begin
					if (wei_last_i && ftm_exhausted_i) begin
						state_nxt    = ST_IDLE;
						layer_done_o = 1'b1;
					end else if (!ftm_exhausted_i && (wb_sufficient_i || wei_last_i)) begin
						state_nxt = ST_FTM_HOLD;
					end else begin
						state_nxt = ST_WEI_HOLD;
					end
				end
			end
			ST_FTM_HOLD: begin
				if (!fb_full_i) begin
					state_nxt = ST_FTM_WAIT;
				end
			end
			ST_FTM_WAIT: begin
				if (!ftm_pending_i) begin
					if (ftm_last_i && wei_exhausted_i) begin
						state_nxt    = ST_IDLE;
						layer_done_o = 1'b1;
					end else if (ftm_last_i) begin
						state_nxt = ST_WEI_HOLD;
					end else begin
						state_nxt = ST_FTM_HOLD;
					end
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state_r <= ST_IDLE;
		end else begin
			state_r <= state_nxt;
		end
	end

	// Both streams load their first chunk on accept.
	assign wei_init_o = accept;
	assign ftm_init_o = accept;

	// A chunk ends in the first WAIT cycle with nothing pending.
	assign wei_advance_o = (state_r == ST_WEI_WAIT) && !wei_pending_i;
	assign ftm_advance_o = (state_r == ST_FTM_WAIT) && !ftm_pending_i;

	// Read issue, held back by the buffer full flags.
	assign ftm_active = (state_r == ST_FTM_HOLD) || (state_r == ST_FTM_WAIT);
	assign rd_start_o = ((state_r == ST_WEI_HOLD) && !wb_full_i)
		|| ((state_r == ST_FTM_HOLD) && !fb_full_i);
	assign rd_req_o   = ftm_active ? ftm_chunk_i : wei_chunk_i;

	// Beats outside a WAIT state are dropped.
	assign wei_beat_o = rd_beat_i && (state_r == ST_WEI_WAIT);
	assign ftm_beat_o = rd_beat_i && (state_r == ST_FTM_WAIT);

	assign wb_we_o    = wei_beat_o ? (cu_mask_t'(1) << wei_cu_sel_i) : '0;
	assign fb_we_o    = ftm_beat_o ? (cu_mask_t'(1) << ftm_cu_sel_i) : '0;
	assign buf_data_o = rd_data_i;

endmodule

//--- hdl/stream_chunker.sv
`timescale 1ns/1ps

module stream_chunker
	import load_pkg::*;
(
	input  logic         aclk,
	input  logic         aresetn,
	input  logic         init_i,
	input  logic         advance_i,
	input  stream_desc_t desc_i,
	output rd_req_t      chunk_o,
	output logic         last_o,
	output logic         exhausted_o,
	output byte_cnt_t    expect_o
);

	// Bursts left after the current chunk.
	nburst_t     rema_r;
	nburst_t     nburst_r;
	addr_t       addr_r;
	last_bytes_t last_bytes_r;
	byte_cnt_t   expect_r;
	logic        last_r;
	logic        exhausted_r;

	// Next chunk, cut from the descriptor or from the bursts left.
	nburst_t     src_rema;
	last_bytes_t src_last_bytes;
	logic        take_last;
	nburst_t     take_bursts;
	byte_cnt_t   take_bytes;

	always_comb begin
		src_rema       = init_i ? desc_i.nburst : rema_r;
		src_last_bytes = init_i ? desc_i.last_bytes : last_bytes_r;
		take_last      = (src_rema <= nburst_t'(UNIT_BURSTS));
		if (take_last) begin
			take_bursts = src_rema;
			// Final burst only carries last_bytes.
			take_bytes  = byte_cnt_t'(src_rema - nburst_t'(1)) * BURST_BYTES
				+ byte_cnt_t'(src_last_bytes);
		end else begin
			take_bursts = nburst_t'(UNIT_BURSTS);
			take_bytes  = byte_cnt_t'(UNIT_BURSTS * BURST_BYTES);
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rema_r      <= '0;
			expect_r    <= '0;
			last_r      <= 1'b0;
			exhausted_r <= 1'b1;
		end else if (init_i) begin
			rema_r      <= src_rema - take_bursts;
			expect_r    <= take_bytes;
			last_r      <= take_last;
			exhausted_r <= 1'b0;
		end else if (advance_i) begin
			if (last_r) begin
				exhausted_r <= 1'b1;
			end else begin
				rema_r   <= src_rema - take_bursts;
				expect_r <= expect_r + take_bytes;
				last_r   <= take_last;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (init_i) begin
			addr_r       <= desc_i.addr;
			nburst_r     <= take_bursts;
			last_bytes_r <= desc_i.last_bytes;
		end else if (advance_i && !last_r) begin
			// Step past the chunk just read.
			addr_r   <= addr_r + addr_t'(nburst_r) * addr_t'(BURST_BYTES);
			nburst_r <= take_bursts;
		end
	end

	assign chunk_o.addr   = addr_r;
	assign chunk_o.nburst = nburst_r;
	assign last_o         = last_r;
	assign exhausted_o    = exhausted_r;
	assign expect_o       = expect_r;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_layer_loader -f sources.f \
	-o tb_layer_loader || exit 1
./obj_dir/tb_layer_loader | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "run_sim: test passed" \
	|| { echo "run_sim: test failed"; exit 1; }

//--- sources.f
hdl/load_pkg.sv
hdl/stream_chunker.sv
hdl/beat_counter.sv
hdl/load_scheduler.sv
hdl/layer_loader.sv
dv/tb_layer_loader.sv
